//--- rtl/mips_settings.svh
`ifndef MIPS_SETTINGS_SVH
`define MIPS_SETTINGS_SVH

// first fetch address out of reset (kseg1 boot vector)
`define MIPS_RESET_PC 32'hbfc00000

// data and address width
`define MIPS_XLEN 32

// architectural integer registers, r0 hardwired to zero
`define MIPS_REG_COUNT 32
`define MIPS_REG_AW 5

`endif

//--- rtl/mipsPkg.sv
`default_nettype none

`include "mips_settings.svh"

package mipsPkg;

    typedef logic [`MIPS_XLEN-1:0] word_t;    // data and addresses
    typedef logic [`MIPS_REG_AW-1:0] regAddr_t;

    typedef enum logic [3:0] {
        aluAdd,
        aluSub,
        aluAnd,
        aluOr,
        aluXor,
        aluSlt,   // signed compare
        aluSll,   // srcB << srcA
        aluLui    // immediate into upper half
    } aluOp_e;

    typedef enum logic [1:0] {
        brNone,
        brBeq,
        brBne
    } branchKind_e;

    // fetch-2 to decode
    typedef struct packed {
        word_t pc;
        word_t instr;   // zero when not valid
        logic  valid;
    } fetchToDecode_t;

    // decode to execute, operands already forwarded
    typedef struct packed {
        word_t       pc;
        aluOp_e      aluOp;
        word_t       srcA;
        word_t       srcB;
        word_t       rtValue;       // branch compare operand
        regAddr_t    dest;
        logic        regWrite;      // never set for r0
        branchKind_e branchKind;
        word_t       branchTarget;
        logic        valid;
    } decodeToExec_t;

    // result of the instruction in execute
    typedef struct packed {
        word_t    value;
        regAddr_t dest;
        logic     regWrite;
    } execResult_t;

    typedef struct packed {
        word_t    pc;
        logic     regWrite;   // stall gated
        regAddr_t dest;
        word_t    data;
    } wbReport_t;

endpackage

`default_nettype wire

//--- rtl/fetchStage.sv
`timescale 1ns/1ns
`default_nettype none

`include "mips_settings.svh"

module fetchStage (
    input  logic                    clk,
    input  logic                    rstN_i,
    input  logic                    instStall_i,
    input  mipsPkg::word_t          instrF_i,     // returns one cycle after pcF_o
    input  logic                    redirect_i,
    input  mipsPkg::word_t          redirectPc_i,
    output mipsPkg::word_t          pcF_o,
    output logic                    instEnF_o,
    output mipsPkg::fetchToDecode_t fetch_o
);

    mipsPkg::word_t pcReg;
    mipsPkg::word_t f2Pc;       // pc whose instruction is on instrF_i
    logic           f2Valid;

    // no point reading memory for a fetch that gets squashed
    assign instEnF_o = ~redirect_i;
    assign pcF_o     = pcReg;

    always_ff @(posedge clk) begin
        if (!rstN_i) begin
            pcReg   <= `MIPS_RESET_PC;
            f2Valid <= 1'b0;
        end else if (!instStall_i) begin
            pcReg   <= redirect_i ? redirectPc_i : pcReg + 32'd4;
            f2Pc    <= pcReg;
            f2Valid <= instEnF_o;   // squashed slot goes invalid
        end
    end

    always_comb begin
        fetch_o.pc    = f2Pc;
        fetch_o.instr = f2Valid ? instrF_i : '0;   // bubble
        fetch_o.valid = f2Valid;
    end

endmodule

`default_nettype wire

//--- rtl/decodeStage.sv
`timescale 1ns/1ns
`default_nettype none

module decodeStage (
    input  logic                    clk,
    input  logic                    rstN_i,
    input  logic                    instStall_i,
    input  logic                    redirect_i,
    input  mipsPkg::fetchToDecode_t fetch_i,
    input  mipsPkg::word_t          rdata1_i,
    input  mipsPkg::word_t          rdata2_i,
    input  mipsPkg::execResult_t    exFwd_i,
    input  mipsPkg::wbReport_t      wb_i,
    output mipsPkg::regAddr_t       raddr1_o,
    output mipsPkg::regAddr_t       raddr2_o,
    output mipsPkg::decodeToExec_t  exec_o
);

    localparam logic [5:0] OpSpecial = 6'h00;
    localparam logic [5:0] OpBeq     = 6'h04;
    localparam logic [5:0] OpBne     = 6'h05;
    localparam logic [5:0] OpAddiu   = 6'h09;
    localparam logic [5:0] OpAndi    = 6'h0c;
    localparam logic [5:0] OpOri     = 6'h0d;
    localparam logic [5:0] OpLui     = 6'h0f;

    mipsPkg::fetchToDecode_t decReg;
    mipsPkg::aluOp_e         aluOp;
    mipsPkg::branchKind_e    brKind;
    logic                    useImm;
    logic                    signExt;
    logic                    destRt;     // I-type writes rt, R-type rd
    logic                    writes;
    logic                    shiftOp;
    mipsPkg::word_t          imm;
    mipsPkg::word_t          rsValue;
    mipsPkg::word_t          rtValue;
    mipsPkg::regAddr_t       dest;

    // execute result wins over writeback, then the register file
    function automatic mipsPkg::word_t fwdSel(input mipsPkg::regAddr_t addr,
                                              input mipsPkg::word_t rf,
                                              input mipsPkg::execResult_t ex,
                                              input mipsPkg::wbReport_t wb);
        if (ex.regWrite && ex.dest == addr)
            return ex.value;
        else if (wb.regWrite && wb.dest == addr)
            return wb.data;
        return rf;
    endfunction

    always_ff @(posedge clk) begin
        if (!rstN_i) begin
            decReg.valid <= 1'b0;
        end else if (!instStall_i) begin
            decReg       <= fetch_i;
            decReg.valid <= fetch_i.valid & ~redirect_i;  // wrong path after branch
        end
    end

    always_comb begin
        aluOp   = mipsPkg::aluAdd;
        brKind  = mipsPkg::brNone;
        useImm  = 1'b0;
        signExt = 1'b1;
        destRt  = 1'b0;
        writes  = 1'b0;
        shiftOp = 1'b0;
        case (decReg.instr[31:26])
            OpSpecial: begin
                writes = 1'b1;
                case (decReg.instr[5:0])
                    6'h21: aluOp = mipsPkg::aluAdd;    // addu
                    6'h23: aluOp = mipsPkg::aluSub;    // subu
                    6'h24: aluOp = mipsPkg::aluAnd;
                    6'h25: aluOp = mipsPkg::aluOr;
                    6'h26: aluOp = mipsPkg::aluXor;
                    6'h2a: aluOp = mipsPkg::aluSlt;
                    6'h00: begin
                        aluOp   = mipsPkg::aluSll;
                        shiftOp = 1'b1;
                    end
                    default: writes = 1'b0;           // unsupported funct
                endcase
            end
            OpAddiu: {useImm, destRt, writes} = 3'b111;
            OpAndi: begin
                aluOp   = mipsPkg::aluAnd;
                {useImm, destRt, writes} = 3'b111;
                signExt = 1'b0;
            end
            OpOri: begin
                aluOp   = mipsPkg::aluOr;
                {useImm, destRt, writes} = 3'b111;
                signExt = 1'b0;
            end
            OpLui: begin
                aluOp   = mipsPkg::aluLui;
                {useImm, destRt, writes} = 3'b111;
                signExt = 1'b0;
            end
            OpBeq: brKind = mipsPkg::brBeq;
            OpBne: brKind = mipsPkg::brBne;
            default: ;  // anything else is a bubble
        endcase
    end

    assign imm = signExt ? {{16{decReg.instr[15]}}, decReg.instr[15:0]}
                         : {16'b0, decReg.instr[15:0]};
    assign dest = destRt ? decReg.instr[20:16] : decReg.instr[15:11];

    assign raddr1_o = decReg.instr[25:21];  // rs
    assign raddr2_o = decReg.instr[20:16];  // rt
    assign rsValue  = fwdSel(raddr1_o, rdata1_i, exFwd_i, wb_i);
    assign rtValue  = fwdSel(raddr2_o, rdata2_i, exFwd_i, wb_i);

    always_comb begin
        exec_o.pc           = decReg.pc;
        exec_o.aluOp        = aluOp;
        exec_o.srcA         = shiftOp ? mipsPkg::word_t'(decReg.instr[10:6]) : rsValue;
        exec_o.srcB         = useImm ? imm : rtValue;
        exec_o.rtValue      = rtValue;
        exec_o.dest         = dest;
        exec_o.regWrite     = decReg.valid & writes & (dest != '0);
        exec_o.branchKind   = decReg.valid ? brKind : mipsPkg::brNone;
        exec_o.branchTarget = {imm[29:0], 2'b00} + decReg.pc + 32'd4;
        exec_o.valid        = decReg.valid;
    end

endmodule

`default_nettype wire

//--- rtl/regFile.sv
`timescale 1ns/1ns
`default_nettype none

`include "mips_settings.svh"

module regFile (
    input  logic                clk,
    input  mipsPkg::regAddr_t   raddr1_i,
    input  mipsPkg::regAddr_t   raddr2_i,
    input  mipsPkg::wbReport_t  wb_i,
    output mipsPkg::word_t      rdata1_o,
    output mipsPkg::word_t      rdata2_o
);

    mipsPkg::word_t regs [1:`MIPS_REG_COUNT-1];   // r0 not stored

    always_ff @(posedge clk) begin
        if (wb_i.regWrite && wb_i.dest != '0) begin
            regs[wb_i.dest] <= wb_i.data;
        end
    end

    // read is combinational, same-cycle writes come through forwarding
    assign rdata1_o = (raddr1_i == '0) ? '0 : regs[raddr1_i];
    assign rdata2_o = (raddr2_i == '0) ? '0 : regs[raddr2_i];

endmodule

`default_nettype wire

//--- rtl/executeStage.sv
`timescale 1ns/1ns
`default_nettype none

module executeStage (
    input  logic                   clk,
    input  logic                   rstN_i,
    input  logic                   instStall_i,
    input  mipsPkg::decodeToExec_t exec_i,
    output mipsPkg::execResult_t   exFwd_o,
    output logic                   redirect_o,
    output mipsPkg::word_t         redirectPc_o,
    output mipsPkg::wbReport_t     wb_o,
    output mipsPkg::word_t         dbgWbPc_o,
    output logic                   dbgWbWen_o,
    output mipsPkg::regAddr_t      dbgWbNum_o,
    output mipsPkg::word_t         dbgWbData_o
);

    mipsPkg::decodeToExec_t execReg;
    mipsPkg::wbReport_t     wbReg;
    mipsPkg::word_t         aluOut;
    logic                   srcEqual;

    always_ff @(posedge clk) begin
        if (!rstN_i) begin
            execReg.valid      <= 1'b0;
            execReg.regWrite   <= 1'b0;
            execReg.branchKind <= mipsPkg::brNone;
        end else if (!instStall_i) begin
            execReg <= exec_i;
        end
    end

    always_comb begin
        case (execReg.aluOp)
            mipsPkg::aluAdd: aluOut = execReg.srcA + execReg.srcB;
            mipsPkg::aluSub: aluOut = execReg.srcA - execReg.srcB;
            mipsPkg::aluAnd: aluOut = execReg.srcA & execReg.srcB;
            mipsPkg::aluOr:  aluOut = execReg.srcA | execReg.srcB;
            mipsPkg::aluXor: aluOut = execReg.srcA ^ execReg.srcB;
            mipsPkg::aluSlt:
                aluOut = mipsPkg::word_t'($signed(execReg.srcA) < $signed(execReg.srcB));
            mipsPkg::aluSll: aluOut = execReg.srcB << execReg.srcA[4:0];
            mipsPkg::aluLui: aluOut = {execReg.srcB[15:0], 16'b0};
            default:         aluOut = execReg.srcA + execReg.srcB;
        endcase
    end

    // branch resolves here, delay slot already in decode
    assign srcEqual     = (execReg.srcA == execReg.rtValue);
    assign redirect_o   = execReg.valid &
                          ((execReg.branchKind == mipsPkg::brBeq &&  srcEqual) ||
                           (execReg.branchKind == mipsPkg::brBne && !srcEqual));
    assign redirectPc_o = execReg.branchTarget;

    always_comb begin
        exFwd_o.value    = aluOut;
        exFwd_o.dest     = execReg.dest;
        exFwd_o.regWrite = execReg.regWrite;
    end

    always_ff @(posedge clk) begin
        if (!rstN_i) begin
            wbReg.regWrite <= 1'b0;
        end else if (!instStall_i) begin
            wbReg.pc       <= execReg.pc;
            wbReg.regWrite <= execReg.regWrite;
            wbReg.dest     <= execReg.dest;
            wbReg.data     <= aluOut;
        end
    end

    // a held writeback entry must not write or report twice
    always_comb begin
        wb_o          = wbReg;
        wb_o.regWrite = wbReg.regWrite & ~instStall_i;
    end

    assign dbgWbPc_o   = wb_o.pc;
    assign dbgWbWen_o  = wb_o.regWrite;
    assign dbgWbNum_o  = wb_o.dest;
    assign dbgWbData_o = wb_o.data;

endmodule

`default_nettype wire

//--- rtl/mipsCore.sv
`timescale 1ns/1ns
`default_nettype none

module mipsCore (
    input  logic               clk,
    input  logic               rstN_i,
    input  mipsPkg::word_t     instrF_i,
    input  logic               instStall_i,
    output mipsPkg::word_t     pcF_o,
    output logic               instEnF_o,
    output mipsPkg::word_t     dbgWbPc_o,
    output logic               dbgWbWen_o,
    output mipsPkg::regAddr_t  dbgWbNum_o,
    output mipsPkg::word_t     dbgWbData_o
);

    mipsPkg::fetchToDecode_t fetchToDecode;
    mipsPkg::decodeToExec_t  decodeToExec;
    mipsPkg::execResult_t    exResult;
    mipsPkg::wbReport_t      wbReport;
    logic                    redirect;      // taken branch in execute
    mipsPkg::word_t          redirectPc;
    mipsPkg::regAddr_t       raddr1;
    mipsPkg::regAddr_t       raddr2;
    mipsPkg::word_t          rdata1;
    mipsPkg::word_t          rdata2;

    fetchStage uFetch (
        .clk          (clk),
        .rstN_i       (rstN_i),
        .instStall_i  (instStall_i),
        .instrF_i     (instrF_i),
        .redirect_i   (redirect),
        .redirectPc_i (redirectPc),
        .pcF_o        (pcF_o),
        .instEnF_o    (instEnF_o),
        .fetch_o      (fetchToDecode)
    );

    decodeStage uDecode (
        .clk         (clk),
        .rstN_i      (rstN_i),
        .instStall_i (instStall_i),
        .redirect_i  (redirect),
        .fetch_i     (fetchToDecode),
        .rdata1_i    (rdata1),
        .rdata2_i    (rdata2),
        .exFwd_i     (exResult),
        .wb_i        (wbReport),
        .raddr1_o    (raddr1),
        .raddr2_o    (raddr2),
        .exec_o      (decodeToExec)
    );

    regFile uRegFile (
        .clk      (clk),
        .raddr1_i (raddr1),
        .raddr2_i (raddr2),
        .wb_i     (wbReport),
        .rdata1_o (rdata1),
        .rdata2_o (rdata2)
    );

    executeStage uExecute (
        .clk          (clk),
        .rstN_i       (rstN_i),
        .instStall_i  (instStall_i),
        .exec_i       (decodeToExec),
        .exFwd_o      (exResult),
        .redirect_o   (redirect),
        .redirectPc_o (redirectPc),
        .wb_o         (wbReport),
        .dbgWbPc_o    (dbgWbPc_o),
        .dbgWbWen_o   (dbgWbWen_o),
        .dbgWbNum_o   (dbgWbNum_o),
        .dbgWbData_o  (dbgWbData_o)
    );

endmodule

`default_nettype wire

//--- testbench/clockGen.sv
`timescale 1ns/1ns
`default_nettype none

module clockGen (
    output logic clk_o,
    output logic rstN_o
);

    localparam int HalfPeriod  = 50;    // 100 ns clock
    localparam int ResetCycles = 2;

    initial begin
        clk_o = 1'b0;
        forever #HalfPeriod clk_o = ~clk_o;
    end

    initial begin
        rstN_o = 1'b0;
        repeat (ResetCycles) @(posedge clk_o);
        #1 rstN_o = 1'b1;   // released just after the edge
    end

endmodule

`default_nettype wire

//--- testbench/wbMonitor.sv
`timescale 1ns/1ns
`default_nettype none

`include "mips_settings.svh"

module wbMonitor #(
    parameter int NumRows  = 1,
    parameter int NumTaken = 0
) (
    input  logic               clk,
    input  logic               rstN_i,
    input  logic               instStall_i,
    input  mipsPkg::word_t     pcF_i,
    input  logic               instEnF_i,
    input  mipsPkg::word_t     dbgWbPc_i,
    input  logic               dbgWbWen_i,
    input  mipsPkg::regAddr_t  dbgWbNum_i,
    input  mipsPkg::word_t     dbgWbData_i,
    input  mipsPkg::wbReport_t expected_i,   // row at rowIdx_o
    output int                 rowIdx_o,
    output int                 errors_o
);

    localparam int FirstLatency = 4;   // pcF_o to debug port without a stall

    int rowCount    = 0;
    int errorCount  = 0;
    int cycle       = 0;   // cycles since reset release
    int squashCount = 0;   // unstalled edges with fetch disabled

    assign rowIdx_o = rowCount;
    assign errors_o = errorCount;

    task automatic checkField(input string name, input mipsPkg::word_t got,
                              input mipsPkg::word_t exp);
        if (got !== exp) begin
            $display("ERROR %s: got %h expected %h at writeback %0d",
                     name, got, exp, rowCount);
            errorCount++;
        end
    endtask

    // mid-cycle sampling where outputs and stall are settled
    always @(negedge clk) begin
        if (rstN_i) begin
            cycle++;
            if (cycle == 1) begin
                if (pcF_i !== `MIPS_RESET_PC) begin
                    $display("ERROR pcF_o: got %h expected %h after reset",
                             pcF_i, `MIPS_RESET_PC);
                    errorCount++;
                end
                if (instEnF_i !== 1'b1) begin
                    $display("ERROR instEnF_o: got %h expected %h after reset",
                             instEnF_i, 1'b1);
                    errorCount++;
                end
            end
            // each taken branch blocks exactly one fetch
            if (!instStall_i && !instEnF_i) begin
                squashCount++;
                if (squashCount > NumTaken) begin
                    $display("fetch enable dropped %0d times for %0d taken branches",
                             squashCount, NumTaken);
                    errorCount++;
                end
            end
            if (dbgWbWen_i) begin
                if (rowCount >= NumRows) begin
                    $display("unexpected extra write to register %0d at pc %h",
                             dbgWbNum_i, dbgWbPc_i);
                    errorCount++;
                end else begin
                    checkField("dbgWbPc_o", dbgWbPc_i, expected_i.pc);
                    checkField("dbgWbNum_o", mipsPkg::word_t'(dbgWbNum_i),
                               mipsPkg::word_t'(expected_i.dest));
                    checkField("dbgWbData_o", dbgWbData_i, expected_i.data);
                    // reset pc sits on pcF_o in cycle 1
                    if (rowCount == 0 && cycle - 1 != FirstLatency) begin
                        $display("first writeback came %0d cycles after its fetch, not %0d",
                                 cycle - 1, FirstLatency);
                        errorCount++;
                    end
                    rowCount++;
                    if (rowCount == NumRows && squashCount != NumTaken) begin
                        $display("ERROR instEnF_o: low on %0h unstalled edges, expected %0h",
                                 squashCount, NumTaken);
                        errorCount++;
                    end
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- testbench/mipsCore_chk.sv
`timescale 1ns/1ns
`default_nettype none

module mipsCore_chk (
    input logic           clk,
    input logic           rstN_i,
    input logic           instStall_i,
    input mipsPkg::word_t pcF_i,
    input logic           dbgWbWen_i
);

    int failCount = 0;

    // held writeback entry stays quiet
    noWbOnStall: assert property (@(posedge clk) instStall_i |-> !dbgWbWen_i)
        else begin
            failCount++;
            $error("writeback enable high while the fetch side is stalled");
        end

    pcAligned: assert property (@(posedge clk) disable iff (!rstN_i) pcF_i[1:0] == 2'b00)
        else begin
            failCount++;
            $error("fetch address is not word aligned");
        end

    pcHeldOnStall: assert property (@(posedge clk) (rstN_i && instStall_i) |=> $stable(pcF_i))
        else begin
            failCount++;
            $error("fetch address moved across a stalled edge");
        end

    noWbInReset: assert property (@(posedge clk) !rstN_i |=> !dbgWbWen_i)
        else begin
            failCount++;
            $error("writeback enable high right after a reset edge");
        end

endmodule

`default_nettype wire

//--- testbench/mipsCoreTb.sv
`timescale 1ns/1ns
`default_nettype none

`include "mips_settings.svh"

module mipsCoreTb;

    localparam int          ProgWords     = 24;
    localparam int          NumRows       = 17;
    localparam int          TakenBranches = 2;    // beq at words 11 and 20
    localparam int          TimeoutCycles = 400;
    localparam int          QuietCycles   = 8;    // no stall while the first writes go through
    localparam int          DrainCycles   = 16;
    localparam logic [31:0] LfsrSeed      = 32'he40a970f;

    logic               clk;
    logic               rstN;
    logic               instStall;
    logic               instEnF;
    logic               dbgWbWen;
    mipsPkg::word_t     instrF;
    mipsPkg::word_t     pcF;
    mipsPkg::word_t     dbgWbPc;
    mipsPkg::word_t     dbgWbData;
    mipsPkg::regAddr_t  dbgWbNum;
    mipsPkg::word_t     progMem [ProgWords];
    mipsPkg::wbReport_t expWrites [NumRows];
    mipsPkg::wbReport_t expRow;
    logic [31:0]        lfsr;
    int                 rowIdx;
    int                 monErrors;

    clockGen uClock (.clk_o(clk), .rstN_o(rstN));

    mipsCore dut (
        .clk         (clk),
        .rstN_i      (rstN),
        .instrF_i    (instrF),
        .instStall_i (instStall),
        .pcF_o       (pcF),
        .instEnF_o   (instEnF),
        .dbgWbPc_o   (dbgWbPc),
        .dbgWbWen_o  (dbgWbWen),
        .dbgWbNum_o  (dbgWbNum),
        .dbgWbData_o (dbgWbData)
    );

    bind mipsCore mipsCore_chk pipeChk (
        .clk         (clk),
        .rstN_i      (rstN_i),
        .instStall_i (instStall_i),
        .pcF_i       (pcF_o),
        .dbgWbWen_i  (dbgWbWen_o)
    );

    assign expRow = (rowIdx < NumRows) ? expWrites[rowIdx] : '0;

    wbMonitor #(.NumRows(NumRows), .NumTaken(TakenBranches)) uMonitor (
        .clk         (clk),
        .rstN_i      (rstN),
        .instStall_i (instStall),
        .pcF_i       (pcF),
        .instEnF_i   (instEnF),
        .dbgWbPc_i   (dbgWbPc),
        .dbgWbWen_i  (dbgWbWen),
        .dbgWbNum_i  (dbgWbNum),
        .dbgWbData_i (dbgWbData),
        .expected_i  (expRow),
        .rowIdx_o    (rowIdx),
        .errors_o    (monErrors)
    );

    function automatic mipsPkg::word_t rType(input logic [5:0] funct, input int rs,
                                             input int rt, input int rd, input int sh);
        return {6'h00, rs[4:0], rt[4:0], rd[4:0], sh[4:0], funct};
    endfunction

    function automatic mipsPkg::word_t iType(input logic [5:0] op, input int rs,
                                             input int rt, input logic [15:0] imm);
        return {op, rs[4:0], rt[4:0], imm};
    endfunction

    function automatic mipsPkg::wbReport_t expectWrite(input int idx, input int num,
                                                       input mipsPkg::word_t data);
        mipsPkg::wbReport_t r;
        r.pc       = `MIPS_RESET_PC + 32'(4 * idx);
        r.regWrite = 1'b1;
        r.dest     = num[4:0];
        r.data     = data;
        return r;
    endfunction

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsrNext(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    // words past the program read as zero which is a nop
    function automatic mipsPkg::word_t fetchWord(input mipsPkg::word_t pc);
        mipsPkg::word_t offset;
        offset = pc - `MIPS_RESET_PC;
        if (offset[1:0] != 2'b00 || (offset >> 2) >= ProgWords)
            return '0;
        return progMem[offset >> 2];
    endfunction

    initial begin
        progMem[0]  = iType(6'h0d, 0, 1, 16'h1234);     // ori   r1, r0, 0x1234
        progMem[1]  = iType(6'h09, 1, 2, 16'hffff);     // addiu r2, r1, -1
        progMem[2]  = rType(6'h21, 1, 2, 3, 0);         // addu  r3, r1, r2
        progMem[3]  = iType(6'h0f, 0, 4, 16'h8000);     // lui   r4, 0x8000
        progMem[4]  = rType(6'h23, 3, 4, 5, 0);         // subu  r5, r3, r4
        progMem[5]  = rType(6'h2a, 4, 3, 6, 0);         // slt   r6, r4, r3
        progMem[6]  = rType(6'h00, 0, 6, 7, 4);         // sll   r7, r6, 4
        progMem[7]  = rType(6'h26, 7, 1, 8, 0);         // xor   r8, r7, r1
        progMem[8]  = iType(6'h0c, 5, 9, 16'hf0f0);     // andi  r9, r5, 0xf0f0
        progMem[9]  = rType(6'h21, 1, 2, 0, 0);         // addu  r0, r1, r2
        progMem[10] = rType(6'h25, 0, 1, 10, 0);        // or    r10, r0, r1
        progMem[11] = iType(6'h04, 1, 10, 16'd3);       // beq   r1, r10 taken
        progMem[12] = iType(6'h09, 0, 11, 16'd5);       // delay slot
        progMem[13] = iType(6'h09, 0, 12, 16'h0bad);    // squashed
        progMem[14] = iType(6'h09, 0, 13, 16'h0bad);    // squashed
        progMem[15] = iType(6'h05, 1, 10, 16'd2);       // bne   r1, r10 not taken
        progMem[16] = iType(6'h09, 11, 14, 16'd7);      // addiu r14, r11, 7
        progMem[17] = rType(6'h24, 14, 1, 15, 0);       // and   r15, r14, r1
        progMem[18] = rType(6'h2a, 3, 4, 16, 0);        // slt   r16, r3, r4
        progMem[19] = rType(6'h23, 0, 14, 17, 0);       // subu  r17, r0, r14
        progMem[20] = iType(6'h04, 0, 0, 16'd2);        // beq   r0, r0 to word 23
        progMem[21] = iType(6'h09, 0, 18, 16'h7fff);    // delay slot
        progMem[22] = iType(6'h09, 0, 19, 16'h0bad);    // squashed
        progMem[23] = iType(6'h09, 18, 20, 16'h8000);   // addiu r20, r18, -0x8000

        // expected writes in program order
        expWrites[0]  = expectWrite(0, 1, 32'h00001234);
        expWrites[1]  = expectWrite(1, 2, 32'h00001233);
        expWrites[2]  = expectWrite(2, 3, 32'h00002467);
        expWrites[3]  = expectWrite(3, 4, 32'h80000000);
        expWrites[4]  = expectWrite(4, 5, 32'h80002467);
        expWrites[5]  = expectWrite(5, 6, 32'h00000001);
        expWrites[6]  = expectWrite(6, 7, 32'h00000010);
        expWrites[7]  = expectWrite(7, 8, 32'h00001224);
        expWrites[8]  = expectWrite(8, 9, 32'h00002060);
        expWrites[9]  = expectWrite(10, 10, 32'h00001234);
        expWrites[10] = expectWrite(12, 11, 32'h00000005);
        expWrites[11] = expectWrite(16, 14, 32'h0000000c);
        expWrites[12] = expectWrite(17, 15, 32'h00000004);
        expWrites[13] = expectWrite(18, 16, 32'h00000000);
        expWrites[14] = expectWrite(19, 17, 32'hfffffff4);
        expWrites[15] = expectWrite(21, 18, 32'h00007fff);
        expWrites[16] = expectWrite(23, 20, 32'hffffffff);
    end

    // instruction memory with one cycle latency that holds while stalled
    initial begin
        mipsPkg::word_t pcSeen;
        logic           stallSeen;
        logic           enSeen;
        logic           rstSeen;
        logic           bitA;
        logic           bitB;
        int             runCycles;
        instrF    = '0;
        instStall = 1'b0;
        lfsr      = LfsrSeed;
        runCycles = 0;
        forever begin
            @(negedge clk);
            pcSeen    = pcF;
            stallSeen = instStall;
            enSeen    = instEnF;
            rstSeen   = rstN;
            @(posedge clk);
            #1;
            if (rstSeen && !stallSeen && enSeen)
                instrF = fetchWord(pcSeen);
            if (rstSeen)
                runCycles++;
            if (runCycles > QuietCycles) begin
                bitA      = lfsr[31];
                lfsr      = lfsrNext(lfsr);
                bitB      = lfsr[31];
                lfsr      = lfsrNext(lfsr);
                instStall = bitA & bitB;   // stalls about one cycle in four
            end
        end
    end

    initial begin
        int waitCycles;
        int timeouts;
        waitCycles = 0;
        timeouts   = 0;
        while (rowIdx < NumRows && waitCycles < TimeoutCycles) begin
            @(posedge clk);
            waitCycles++;
        end
        if (rowIdx < NumRows) begin
            $display("timed out with %0d of %0d writebacks seen after %0d cycles",
                     rowIdx, NumRows, waitCycles);
            timeouts = 1;
        end
        // extra cycles catch duplicate or late writes
        for (int i = 0; i < DrainCycles; i++)
            @(posedge clk);
        $display("%0d monitor errors, %0d assertion failures, %0d timeouts",
                 monErrors, dut.pipeChk.failCount, timeouts);
        if (monErrors == 0 && dut.pipeChk.failCount == 0 && timeouts == 0)
            $display("Test passed");
        else
            $display("Test failed");
        $finish;
    end

endmodule

`default_nettype wire

//--- list.f
+incdir+rtl
rtl/mipsPkg.sv
rtl/fetchStage.sv
rtl/decodeStage.sv
rtl/regFile.sv
rtl/executeStage.sv
rtl/mipsCore.sv
testbench/clockGen.sv
testbench/wbMonitor.sv
testbench/mipsCore_chk.sv
testbench/mipsCoreTb.sv
